// File: rtl/routerPkg.sv
package routerPkg;

  // ####################################################################
  // Ports of the mesh router
  // ####################################################################

  localparam int numPorts = 5;

  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  // ####################################################################
  // Flit formats
  // ####################################################################

  // One-hot style identifier codes in the top three bits of every flit
  localparam logic [2:0] flitIdHead = 3'b001;
  localparam logic [2:0] flitIdBody = 3'b010;
  localparam logic [2:0] flitIdTail = 3'b100;

  typedef struct packed {
    logic [2:0]  flitId;
    logic [11:0] length;
    logic        spare;
  } headFlitT;

  typedef struct packed {
    logic [2:0]  flitId;
    logic [12:0] data;
  } bodyFlitT;

  // The same word reads as a header or as a body word depending on flitId
  typedef union packed {
    headFlitT head;
    bodyFlitT body;
  } flitT;

  typedef flitT [numPorts-1:0] portFlitsT;

  typedef logic [numPorts-1:0] portBitsT;

endpackage

// File: rtl/arbPkg.sv
package arbPkg;

  import routerPkg::*;

  // ####################################################################
  // Grant timing and state
  // ####################################################################

  // Wide enough for the full header length field
  localparam int timerWidth = 12;

  // Bit 0 is idle, bits 1 to 5 grant L, N, E, W and S
  typedef logic [5:0] grantStateT;

  localparam grantStateT grantIdle = 6'b000001;

  // Everything the grant FSM looks at, one bit per port in each field
  typedef struct packed {
    portBitsT req;
    portBitsT timesUp;
  } portStatusT;

endpackage

// File: rtl/portDecoder.sv
`timescale 1ns/1ps

module portDecoder
  import routerPkg::*;
  import arbPkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  portFlitsT                            inFlits,
  input  portBitsT                             inValid,
  output portBitsT                             req,
  output portBitsT                             headLoad,
  output logic [numPorts-1:0][timerWidth-1:0]  lengths
);

  portBitsT isHead;
  portBitsT isBody;
  portBitsT isTail;
  portBitsT isLegal;
  portBitsT packetOpen;

  // Header view for the identifier and length, body view for the rest
  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      isHead[p]  = (inFlits[p].head.flitId == flitIdHead);
      isBody[p]  = (inFlits[p].body.flitId == flitIdBody);
      isTail[p]  = (inFlits[p].body.flitId == flitIdTail);
      lengths[p] = inFlits[p].head.length;
    end
  end

  assign isLegal  = isHead | isBody | isTail;
  assign headLoad = inValid & isHead;

  // Request goes up with the header itself and stays up while the packet is open
  assign req = packetOpen | headLoad;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      packetOpen <= '0;
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (headLoad[p])
          packetOpen[p] <= 1'b1;
        // A word with an unknown identifier also ends the packet, so it cannot hold the link
        else if (inValid[p] && (isTail[p] || !isLegal[p]))
          packetOpen[p] <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/grantTimer.sv
`timescale 1ns/1ps

module grantTimer
  import arbPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  headLoad,
  input  logic [timerWidth-1:0] length,
  input  logic                  runTimer,
  output logic                  timesUp
);

  logic [timerWidth-1:0] count;
  logic [timerWidth-1:0] holdLength;

  // Length of the latest header seen on this port
  always_ff @(posedge clk)
  begin
    if (rst)
      holdLength <= '0;
    else if (headLoad)
      holdLength <= length;
  end

  // Counts only while the port keeps its grant, starts over otherwise
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (runTimer)
      count <= count + 1'b1;
    else
      count <= '0;
  end

  assign timesUp = (count == holdLength);

endmodule

// File: rtl/grantFsm.sv
`timescale 1ns/1ps

module grantFsm
  import routerPkg::*;
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portStatusT status,
  output grantStateT grant,
  output portBitsT   runTimer
);

  grantStateT grantNext;

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= grantIdle;
    else
      grant <= grantNext;
  end

  // ####################################################################
  // Hold or rotate
  // ####################################################################

  always_comb
  begin
    logic        isIdle;
    logic        legal;
    logic        found;
    int unsigned holder;
    int unsigned start;
    int unsigned cand;

    isIdle    = 1'b0;
    legal     = 1'b1;
    found     = 1'b0;
    holder    = portL;
    start     = portL;
    cand      = portL;
    runTimer  = '0;
    grantNext = grantIdle;

    case (grant)
      grantIdle: isIdle = 1'b1;
      6'b000010: holder = portL;
      6'b000100: holder = portN;
      6'b001000: holder = portE;
      6'b010000: holder = portW;
      6'b100000: holder = portS;
      default:   legal  = 1'b0;
    endcase

    if (legal && !isIdle && status.req[holder] && !status.timesUp[holder])
    begin
      // Holder still has packet left and time on its timer
      runTimer[holder] = 1'b1;
      grantNext        = grant;
    end
    else if (legal)
    begin
      // From idle the search starts at L, otherwise at the port after the holder
      if (isIdle)
        start = portL;
      else
        start = (holder + 1) % numPorts;

      for (int unsigned k = 0; k < numPorts; k++)
      begin
        cand = (start + k) % numPorts;
        if (!found && status.req[cand])
        begin
          found                = 1'b1;
          grantNext            = '0;
          grantNext[cand + 1]  = 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/linkMux.sv
`timescale 1ns/1ps

module linkMux
  import routerPkg::*;
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  grantStateT grant,
  input  portFlitsT  inFlits,
  input  portBitsT   inValid,
  output flitT       outFlit,
  output logic       outValid
);

  flitT selFlit;
  logic selValid;

  // Idle selects nothing and leaves the link invalid
  always_comb
  begin
    selFlit  = '0;
    selValid = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        selFlit  = inFlits[p];
        selValid = inValid[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

endmodule

// File: rtl/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
  import routerPkg::*;
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portFlitsT  inFlits,
  input  portBitsT   inValid,
  output grantStateT grant,
  output flitT       outFlit,
  output logic       outValid
);

  portBitsT                            req;
  portBitsT                            headLoad;
  logic [numPorts-1:0][timerWidth-1:0] lengths;
  portBitsT                            timesUp;
  portBitsT                            runTimer;
  portStatusT                          status;

  assign status = '{req: req, timesUp: timesUp};

  // ####################################################################
  // Request side
  // ####################################################################

  portDecoder portDecoder_inst (
    .clk      (clk),
    .rst      (rst),
    .inFlits  (inFlits),
    .inValid  (inValid),
    .req      (req),
    .headLoad (headLoad),
    .lengths  (lengths)
  );

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    grantTimer grantTimer_inst (
      .clk      (clk),
      .rst      (rst),
      .headLoad (headLoad[p]),
      .length   (lengths[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  // ####################################################################
  // Grant and link
  // ####################################################################

  grantFsm grantFsm_inst (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .grant    (grant),
    .runTimer (runTimer)
  );

  linkMux linkMux_inst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlits  (inFlits),
    .inValid  (inValid),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: tb/outputArbiter_chk.sv
`timescale 1ns/1ps

module outputArbiterChk
  import routerPkg::*;
  import arbPkg::*;
(
  input logic       clk,
  input logic       rst,
  input grantStateT grant,
  input logic       outValid,
  input portBitsT   req,
  input portBitsT   timesUp
);

  // Ports whose grant must survive the next clock
  portBitsT holding;

  assign holding = grant[5:1] & req & ~timesUp;

  // ####################################################################
  // Grant legality
  // ####################################################################

  assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot");

  assert property (@(posedge clk) rst |=> (grant == grantIdle))
    else $error("grant is not idle in the cycle after reset");

  assert property (@(posedge clk) disable iff (rst) outValid |-> ($past(grant) != grantIdle))
    else $error("link is valid although the previous grant was idle");

  assert property (@(posedge clk) disable iff (rst) (holding != '0) |=> (grant == $past(grant)))
    else $error("holder with request and time left lost the grant");

endmodule

// File: tb/outputArbiterTb.sv
`timescale 1ns/1ps

module outputArbiterTb
  import routerPkg::*;
  import arbPkg::*;
();

  // Nine hex words per cycle: five flits, valid, grant, outFlit, outValid
  localparam int wordsPerRec   = 9;
  localparam int maxRecords    = 64;
  localparam int resetTimeout  = 40;

  logic       clk;
  logic       rst = 1'b1;
  portFlitsT  inFlits;
  portBitsT   inValid;
  grantStateT grant;
  flitT       outFlit;
  logic       outValid;

  logic [15:0] testData [0:maxRecords*wordsPerRec-1];
  int          recIdx;
  int          waitCount;

  outputArbiter outputArbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .inFlits  (inFlits),
    .inValid  (inValid),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  bind outputArbiter outputArbiterChk outputArbiterChk_inst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .outValid (outValid),
    .req      (req),
    .timesUp  (timesUp)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is released on a falling edge after 16 rising edges
  initial
  begin
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  // ####################################################################
  // Helpers
  // ####################################################################

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compareValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      failRun("Stopping at the first wrong output value");
    end
  endtask

  function automatic logic endMarkerAt(input int idx);
    int base;
    base = idx * wordsPerRec;
    return (testData[base] === 16'hFFFF) && (testData[base + 5] === 16'hFFFF);
  endfunction

  task automatic driveRecord(input int idx);
    int base;
    base = idx * wordsPerRec;
    for (int p = 0; p < numPorts; p++)
      inFlits[p] = flitT'(testData[base + p]);
    inValid = testData[base + 5][numPorts-1:0];
  endtask

  task automatic checkRecord(input int idx);
    int base;
    base = idx * wordsPerRec;
    compareValue("grant", 16'(grant), testData[base + 6]);
    compareValue("outFlit", 16'(outFlit), testData[base + 7]);
    compareValue("outValid", 16'(outValid), testData[base + 8]);
  endtask

  // ####################################################################
  // Stimulus and checking
  // ####################################################################

  initial
  begin
    inFlits    = '0;
    inValid    = '0;
    recIdx     = 0;
    $readmemh("tb/outputArbiter_testdata.txt", testData);

    waitCount = 0;
    while (rst !== 1'b0)
    begin
      @(posedge clk);
      waitCount++;
      if (waitCount > resetTimeout)
        failRun("Reset was not released in time");
    end

    // Each record is driven on one falling edge and checked on the next
    @(negedge clk);
    while (!endMarkerAt(recIdx))
    begin
      driveRecord(recIdx);
      @(negedge clk);
      checkRecord(recIdx);
      recIdx++;
      if (recIdx >= maxRecords)
        failRun("The test data has no end marker within the record limit");
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: tb/outputArbiter_testdata.txt
// flitL flitN flitE flitW flitS valid(bit0=L..bit4=S) | grant outFlit outValid
// One line per clock cycle in hex, a line of FFFF words ends the run
// Idle after reset
0000 0000 0000 0000 0000 0000 0001 0000 0000
0000 0000 0000 0000 0000 0000 0001 0000 0000
0000 0000 0000 0000 0000 0000 0001 0000 0000
// East and West headers together, East wins from idle
0000 0000 2002 2004 0000 000C 0008 0000 0000
0000 0000 4123 0000 0000 0004 0008 4123 0001
0000 0000 4124 0000 0000 0004 0010 4124 0001
0000 0000 8125 4200 0000 000C 0010 4200 0001
0000 0000 0000 4201 0000 0008 0010 4201 0001
0000 0000 0000 4202 0000 0008 0010 4202 0001
0000 0000 0000 8203 0000 0008 0010 8203 0001
0000 0000 0000 0000 0000 0000 0001 0000 0000
// North alone with length 3, then South joins
0000 2006 0000 0000 0000 0002 0004 0000 0000
0000 4301 0000 0000 0000 0002 0004 4301 0001
0000 4302 0000 0000 0000 0002 0004 4302 0001
0000 4303 0000 0000 0000 0002 0004 4303 0001
0000 4304 0000 0000 0000 0002 0004 4304 0001
0000 4305 0000 0000 2004 0012 0004 4305 0001
0000 4306 0000 0000 0000 0002 0004 4306 0001
0000 4307 0000 0000 0000 0002 0004 4307 0001
0000 4308 0000 0000 0000 0002 0020 4308 0001
// South holds, then rotation through L, N, E and W
2002 0000 2002 2002 4401 001D 0020 4401 0001
0000 0000 0000 0000 4402 0010 0020 4402 0001
0000 0000 0000 0000 8403 0010 0002 8403 0001
4501 0000 0000 0000 0000 0001 0002 4501 0001
8502 0000 0000 0000 0000 0001 0004 8502 0001
0000 8309 0000 0000 0000 0002 0004 8309 0001
0000 0000 0000 0000 0000 0000 0008 0000 0000
0000 0000 8601 0000 0000 0004 0008 8601 0001
0000 0000 0000 4701 0000 0008 0010 0000 0000
0000 0000 0000 8702 0000 0008 0010 8702 0001
0000 0000 0000 0000 0000 0000 0001 0000 0000
0000 0000 0000 0000 0000 0000 0001 0000 0000
// End marker
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF

// File: sources.f
rtl/routerPkg.sv
rtl/arbPkg.sv
rtl/portDecoder.sv
rtl/grantTimer.sv
rtl/grantFsm.sv
rtl/linkMux.sv
rtl/outputArbiter.sv
tb/outputArbiter_chk.sv
tb/outputArbiterTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= outputArbiterTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
